// ==== files.f ====
common/fft_twiddle_pkg.sv
twiddle/twiddle_gen.sv
design/cmplx_mult_scale.sv
design/twiddle_mult.sv
test/twiddle_mult_asserts.sv
test/tb_twiddle_mult.sv

// ==== Makefile ====
# Verilator build and run for the twiddle multiplier testbench.

VERILATOR ?= verilator
TOP       ?= tb_twiddle_mult
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF '$(PASS_MSG)'; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_twiddle_mult.sv ====
module tb_twiddle_mult
    import fft_twiddle_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_W     = 32;
    localparam int HALF_W     = DATA_W / 2;
    localparam int START_CNT  = 64;
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 10;
    localparam int WINDOW     = STAGE_LEN * NUM_STAGES;
    localparam int N_RANDOM   = 2000;

    // reset, two samples after reset, full sweep, first block, later blocks, random.
    localparam int N_TESTS = RST_CYCLES + 2 + 256 + STAGE_LEN + (WINDOW - STAGE_LEN)
                             + N_RANDOM;
    localparam int TIMEOUT = (N_TESTS + 20) * CLK_PERIOD;

    localparam logic [HALF_W-1:0] HALF_MIN = {1'b1, {(HALF_W-1){1'b0}}};
    localparam logic [HALF_W-1:0] HALF_MAX = {1'b0, {(HALF_W-1){1'b1}}};

    logic              clk;
    logic              rst_n;
    cnt_t              cnt;
    logic [DATA_W-1:0] data_in;
    logic [DATA_W-1:0] data_out;

    int      seed;
    tw_idx_t prev_idx;                             // index picked by the previous count.

    // ****************************************
    // clock and DUT.
    // ****************************************

    always #(CLK_PERIOD / 2) clk = ~clk;

    twiddle_mult #(
        .DATA_W    (DATA_W),
        .START_CNT (START_CNT)
    ) i_twiddle_mult (
        .clk      (clk),
        .rst_n    (rst_n),
        .cnt      (cnt),
        .data_in  (data_in),
        .data_out (data_out)
    );

    // ****************************************
    // reference model.
    // ****************************************

    // stage block g steps through the table with stride 2^g, wrapping at 32.
    function automatic tw_idx_t sched_index(cnt_t c);
        int ofs;
        int grp;
        ofs = int'(c) - START_CNT;
        if (ofs < 0 || ofs >= WINDOW) begin
            return '0;
        end
        grp = ofs / STAGE_LEN;
        return tw_idx_t'((ofs % (STAGE_LEN >> grp)) << grp);
    endfunction

    function automatic logic signed [HALF_W-1:0] rescale(int acc);
        int shifted;
        shifted = acc >>> TW_FRAC;
        return shifted[HALF_W-1:0];                // only the low half is kept, so it wraps.
    endfunction

    function automatic logic [DATA_W-1:0] twiddle_model(logic [DATA_W-1:0] d, tw_idx_t idx);
        int re;
        int im;
        int cr;
        int ci;
        re = int'($signed(d[DATA_W-1:HALF_W]));
        im = int'($signed(d[HALF_W-1:0]));
        cr = int'(TW_RE[idx]);
        ci = int'(TW_IM[idx]);
        return {rescale(re * cr - im * ci), rescale(re * ci + im * cr)};
    endfunction

    // ****************************************
    // checks.
    // ****************************************

    task automatic stop_on_mismatch(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_packed(logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp, string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s: got %h, expected %h (cnt %0d)",
                                       what, got, exp, cnt));
        end
    endtask

    task automatic check_half(logic signed [HALF_W-1:0] got, logic signed [HALF_W-1:0] exp,
                              string what);
        if (got !== exp) begin
            stop_on_mismatch($sformatf("%s: got %0d, expected %0d (cnt %0d)",
                                       what, got, exp, cnt));
        end
    endtask

    // ****************************************
    // stimulus.
    // ****************************************

    function automatic logic [DATA_W-1:0] random_data();
        logic [DATA_W-1:0] d;
        d = $random(seed);
        return d;
    endfunction

    // a share of the samples carries the most negative or most positive halves.
    function automatic logic [DATA_W-1:0] edge_data();
        logic [DATA_W-1:0] d;
        logic [2:0]        pick;
        d    = $random(seed);
        pick = 3'($random(seed));
        case (pick)
            3'd0: d[DATA_W-1:HALF_W] = HALF_MIN;
            3'd1: d[HALF_W-1:0] = HALF_MIN;
            3'd2: d = {HALF_MIN, HALF_MIN};
            3'd3: d = {HALF_MAX, HALF_MIN};
            3'd4: d = {HALF_MAX, HALF_MAX};
            default: ;
        endcase
        return d;
    endfunction

    // Drives one sample on the falling edge and checks it at the next one.
    // The sample is scaled by the coefficient of the count driven a cycle earlier.
    task automatic step(cnt_t c, logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] expected;
        logic              unity;
        cnt      = c;
        data_in  = d;
        expected = twiddle_model(d, prev_idx);
        unity    = (prev_idx == '0);
        prev_idx = sched_index(c);
        @(negedge clk);
        if (unity) begin
            // times 1024 and back down by 2^10 leaves the sample as it was.
            check_packed(data_out, d, "unity coefficient did not pass the sample through");
        end else begin
            check_half(data_out[DATA_W-1:HALF_W], expected[DATA_W-1:HALF_W], "real half");
            check_half(data_out[HALF_W-1:0], expected[HALF_W-1:0], "imaginary half");
        end
    endtask

    initial begin
        seed     = 32'he7e5;
        clk      = 1'b0;
        rst_n    = 1'b0;
        cnt      = '0;
        data_in  = '0;
        prev_idx = '0;                             // the reset coefficient is unity.

        repeat (RST_CYCLES) @(negedge clk);
        check_packed(data_out, '0, "output during reset");
        rst_n = 1'b1;

        // the first sample after reset meets the unity reset coefficient.
        step(cnt_t'($random(seed)), random_data());
        step(cnt_t'($random(seed)), random_data());

        // full count sweep. Outside the window the samples come back unchanged.
        for (int i = 0; i < 256; i++) begin
            step(cnt_t'(i), random_data());
        end

        // first stage block walks every index.
        for (int i = 0; i < STAGE_LEN; i++) begin
            step(cnt_t'(START_CNT + i), random_data());
        end

        // later blocks use strides of 2, 4, 8 and 16.
        for (int i = STAGE_LEN; i < WINDOW; i++) begin
            step(cnt_t'(START_CNT + i), random_data());
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            step(cnt_t'($random(seed)), edge_data());
        end

        $display("PASS: all tests");
        $finish;
    end

    // ****************************************
    // watchdog.
    // ****************************************

    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped by the watchdog");
    end

endmodule

// ==== test/twiddle_mult_asserts.sv ====
module twiddle_mult_asserts
    import fft_twiddle_pkg::*;
#(
    parameter int START_CNT = 64
) (
    input logic     clk,
    input logic     rst_n,
    input cnt_t     cnt,
    input tw_coef_t coef_re,
    input tw_coef_t coef_im
);
    timeunit 1ns;
    timeprecision 100ps;

    int   offset;
    logic is_unity;
    logic is_w16;

    assign offset   = int'(cnt) - START_CNT;
    assign is_unity = (coef_re == TW_RE[0]) && (coef_im == TW_IM[0]);
    assign is_w16   = (coef_re == TW_RE[16]) && (coef_im == TW_IM[16]);   // the -j entry.

    a_reset_unity: assert property (@(posedge clk) !rst_n |=> is_unity)
        else $error("coefficient is not unity after reset");

    a_outside_unity: assert property (@(posedge clk)
        rst_n && (offset < 0 || offset >= STAGE_LEN * NUM_STAGES) |=> is_unity)
        else $error("coefficient is not unity after a count outside the window");

    // the last block alternates between index 0 and index 16.
    a_last_block: assert property (@(posedge clk)
        rst_n && offset >= 4 * STAGE_LEN && offset < 5 * STAGE_LEN |=> is_unity || is_w16)
        else $error("coefficient in the last stage block is neither index 0 nor 16");

endmodule

bind twiddle_gen twiddle_mult_asserts #(
    .START_CNT (START_CNT)
) i_twiddle_mult_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .cnt     (cnt),
    .coef_re (coef_re),
    .coef_im (coef_im)
);

// ==== design/twiddle_mult.sv ====
module twiddle_mult
    import fft_twiddle_pkg::*;
#(
    parameter int DATA_W    = 32,
    parameter int START_CNT = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cnt_t              cnt,
    input  logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out
);

    // the coefficient is registered one cycle ahead of the sample it scales.
    tw_coef_t coef_re;
    tw_coef_t coef_im;

    twiddle_gen #(
        .START_CNT (START_CNT)
    ) i_twiddle_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .cnt     (cnt),
        .coef_re (coef_re),
        .coef_im (coef_im)
    );

    cmplx_mult_scale #(
        .DATA_W (DATA_W)
    ) i_cmplx_mult_scale (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_in  (data_in),
        .coef_re  (coef_re),
        .coef_im  (coef_im),
        .data_out (data_out)
    );

endmodule

// ==== design/cmplx_mult_scale.sv ====
module cmplx_mult_scale
    import fft_twiddle_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] data_in,
    input  tw_coef_t          coef_re,
    input  tw_coef_t          coef_im,
    output logic [DATA_W-1:0] data_out
);

    localparam int HALF_W = DATA_W / 2;
    localparam int PROD_W = HALF_W + TW_W;         // one full product.
    localparam int SUM_W  = PROD_W + 1;            // room for the add or subtract.

    logic signed [HALF_W-1:0] in_re;
    logic signed [HALF_W-1:0] in_im;
    logic signed [PROD_W-1:0] p_rr;
    logic signed [PROD_W-1:0] p_ii;
    logic signed [PROD_W-1:0] p_ri;
    logic signed [PROD_W-1:0] p_ir;
    logic signed [SUM_W-1:0]  sum_re;
    logic signed [SUM_W-1:0]  sum_im;
    logic signed [HALF_W-1:0] out_re;
    logic signed [HALF_W-1:0] out_im;

    // ****************************************
    // complex product.
    // ****************************************

    assign in_re = data_in[DATA_W-1:HALF_W];       // real half sits on top.
    assign in_im = data_in[HALF_W-1:0];

    assign p_rr = PROD_W'(in_re) * PROD_W'(coef_re);
    assign p_ii = PROD_W'(in_im) * PROD_W'(coef_im);
    assign p_ri = PROD_W'(in_re) * PROD_W'(coef_im);
    assign p_ir = PROD_W'(in_im) * PROD_W'(coef_re);

    assign sum_re = $signed({p_rr[PROD_W-1], p_rr}) - $signed({p_ii[PROD_W-1], p_ii});
    assign sum_im = $signed({p_ri[PROD_W-1], p_ri}) + $signed({p_ir[PROD_W-1], p_ir});

    // An arithmetic shift by TW_FRAC followed by keeping the low HALF_W bits
    // is the same as taking this slice. Results that overflow simply wrap.
    assign out_re = sum_re[TW_FRAC+HALF_W-1:TW_FRAC];
    assign out_im = sum_im[TW_FRAC+HALF_W-1:TW_FRAC];

    // ****************************************
    // output register.
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else begin
            data_out <= {out_re, out_im};
        end
    end

endmodule

// ==== twiddle/twiddle_gen.sv ====
module twiddle_gen
    import fft_twiddle_pkg::*;
#(
    parameter int START_CNT = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  cnt_t     cnt,
    output tw_coef_t coef_re,
    output tw_coef_t coef_im
);

    // two extra bits hold the sign and the full range of cnt - START_CNT.
    localparam int OFS_W     = CNT_W + 2;
    localparam int GRP_SHIFT = $clog2(STAGE_LEN);

    localparam logic signed [OFS_W-1:0] START_OFS = OFS_W'(START_CNT);
    localparam logic signed [OFS_W-1:0] WIN_END   = OFS_W'(STAGE_LEN * NUM_STAGES);

    logic signed [OFS_W-1:0]        offset;
    logic                           in_window;
    logic [CNT_W-1:0]               ofs_u;
    logic [CNT_W-GRP_SHIFT-1:0]     stage_grp;
    logic [GRP_SHIFT-1:0]           stage_pos;
    tw_idx_t                        tw_idx;

    // ****************************************
    // schedule decode.
    // ****************************************

    assign offset    = $signed({2'b00, cnt}) - START_OFS;
    assign in_window = !offset[OFS_W-1] && (offset < WIN_END);

    // inside the window the offset is below 160 and fits CNT_W bits.
    assign ofs_u     = offset[CNT_W-1:0];
    assign stage_grp = ofs_u[CNT_W-1:GRP_SHIFT];   // which 32-count block.
    assign stage_pos = ofs_u[GRP_SHIFT-1:0];       // position inside the block.

    // Each later block walks the table with a doubled stride, so block g
    // uses (pos mod (32 >> g)) << g. Shifting left inside a 5-bit result
    // drops the top g bits, which is exactly that modulo.
    always_comb begin
        if (in_window) begin
            tw_idx = stage_pos << stage_grp;
        end else begin
            tw_idx = '0;                           // unity outside the schedule.
        end
    end

    // ****************************************
    // coefficient register.
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            coef_re <= TW_RE[0];
            coef_im <= TW_IM[0];
        end else begin
            coef_re <= TW_RE[tw_idx];
            coef_im <= TW_IM[tw_idx];
        end
    end

endmodule

// ==== common/fft_twiddle_pkg.sv ====
package fft_twiddle_pkg;

    // ****************************************
    // widths and schedule.
    // ****************************************

    localparam int TW_W       = 12;
    localparam int TW_FRAC    = 10;                // 1.0 is 1024 in this format.
    localparam int TW_NUM     = 32;
    localparam int TW_IDX_W   = $clog2(TW_NUM);
    localparam int CNT_W      = 8;
    localparam int STAGE_LEN  = 32;                // counts in one stage block.
    localparam int NUM_STAGES = 5;                 // window covers offsets 0 to 159.

    typedef logic [CNT_W-1:0]        cnt_t;
    typedef logic [TW_IDX_W-1:0]     tw_idx_t;
    typedef logic signed [TW_W-1:0]  tw_coef_t;

    // ****************************************
    // coefficient table of W64^k for k = 0..31.
    // ****************************************

    // real parts run from cos(0) down to cos(31*pi/32).
    localparam tw_coef_t TW_RE [TW_NUM] = '{
        12'sd1024,
        12'sd1019,
        12'sd1004,
        12'sd979,
        12'sd946,
        12'sd903,
        12'sd851,
        12'sd791,
        12'sd724,
        12'sd649,
        12'sd568,
        12'sd482,
        12'sd391,
        12'sd297,
        12'sd199,
        12'sd100,
        12'sd0,                                    // quarter turn.
        -12'sd101,
        -12'sd200,
        -12'sd298,
        -12'sd392,
        -12'sd483,
        -12'sd569,
        -12'sd650,
        -12'sd725,
        -12'sd792,
        -12'sd852,
        -12'sd904,
        -12'sd947,
        -12'sd980,
        -12'sd1005,
        -12'sd1020
    };

    // imaginary parts carry the minus sign of the forward transform.
    localparam tw_coef_t TW_IM [TW_NUM] = '{
        12'sd0,
        -12'sd101,
        -12'sd200,
        -12'sd298,
        -12'sd392,
        -12'sd483,
        -12'sd569,
        -12'sd650,
        -12'sd725,
        -12'sd792,
        -12'sd852,
        -12'sd904,
        -12'sd947,
        -12'sd980,
        -12'sd1005,
        -12'sd1020,
        -12'sd1024,                                // the only entry at full scale.
        -12'sd1020,
        -12'sd1005,
        -12'sd980,
        -12'sd947,
        -12'sd904,
        -12'sd852,
        -12'sd792,
        -12'sd725,
        -12'sd650,
        -12'sd569,
        -12'sd483,
        -12'sd392,
        -12'sd298,
        -12'sd200,
        -12'sd101
    };

endpackage
